//--- logic/sdramPkg.sv
/*
 * Shared definitions for the SDRAM controller. Holds timing in clock cycles,
 * the command and state encodings and the APB address layout.
 */
package sdramPkg;

    // ----------------------------------------
    // Geometry and widths
    // ----------------------------------------
    localparam int dataWidth = 16;
    localparam int rowWidth  = 13;
    localparam logic [31:0] addrLimit = 32'h0400_0000; // First byte address past the part

    // ----------------------------------------
    // Timing in Clock cycles
    // ----------------------------------------
    localparam int initWaitCycles   = 100;  // NOP wait after power-up
    localparam int tRP              = 3;    // Precharge period
    localparam int tRC              = 7;    // Refresh cycle time
    localparam int tRCD             = 3;    // Activate to read or write
    localparam int casLatency       = 2;
    localparam int tDPL             = 2;    // Write recovery before precharge
    localparam int tMRD             = 2;    // Mode register set time
    localparam int initRefreshCount = 8;
    localparam int refreshInterval  = 390;

    // Burst 1, sequential, CL 2, single location write
    localparam logic [rowWidth-1:0] modeRegValue = 13'b000_1_00_010_0_000;

    localparam int cntWidth        = $clog2(initWaitCycles);      // Longest single delay
    localparam int initRefWidth    = $clog2(initRefreshCount + 1);
    localparam int refreshCntWidth = $clog2(refreshInterval);

    // Command pins as {RAS_N, CAS_N, WE_N}
    typedef enum logic [2:0] {
        CMD_MODE_SET     = 3'b000,
        CMD_AUTO_REFRESH = 3'b001,
        CMD_PRECHARGE    = 3'b010,
        CMD_ACTIVATE     = 3'b011,
        CMD_WRITE        = 3'b100,
        CMD_READ         = 3'b101,
        CMD_NOP          = 3'b111
    } sdramCmdE;

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PREA,
        INIT_REFRESH,
        INIT_NOP,
        INIT_MODE,
        IDLE,
        ACTIVATE,
        READ,
        WRITE,
        PRECHARGE,
        REFRESH
    } sdramStateE;

    // Byte address split into SDRAM coordinates
    typedef struct packed {
        logic [5:0]          unused;  // Must be zero for an in-range access
        logic [1:0]          bank;
        logic [rowWidth-1:0] row;
        logic [9:0]          col;
        logic                byteSel;
    } sdramAddrFieldsS;

    typedef union packed {
        logic [31:0]     word;
        sdramAddrFieldsS fields;
    } sdramAddrU;

endpackage

//--- logic/sdramReqIf.sv
/*
 * Single access request from the APB bridge to the SDRAM controller.
 * Fields stay stable while reqValid is high; reqDone closes the access.
 */
interface sdramReqIf;
    import sdramPkg::*;

    logic                 reqValid;
    logic                 reqWrite;
    sdramAddrU            reqAddr;
    logic [dataWidth-1:0] reqWdata;
    logic                 reqDone;   // One cycle, last precharge cycle
    logic [dataWidth-1:0] rdata;

    modport bridge (
        output reqValid, reqWrite, reqAddr, reqWdata,
        input  reqDone, rdata
    );

    modport ctrl (
        input  reqValid, reqWrite, reqAddr, reqWdata,
        output reqDone, rdata
    );

endinterface

//--- logic/apbSdramBridge.sv
/*
 * APB slave in front of the SDRAM controller. Each transfer becomes one
 * controller request and PREADY stays low until the controller finishes.
 */
module apbSdramBridge (
    input  logic        Clock,
    input  logic        rstN,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    sdramReqIf.bridge   req
);
    import sdramPkg::*;

    sdramAddrU setupAddr;
    logic      setupPhase;
    logic      addrBad;

    assign setupAddr.word = paddr;

    // New transfer only when nothing is pending or completing
    assign setupPhase = psel && !penable && !req.reqValid && !pready;
    assign addrBad    = (setupAddr.word >= addrLimit);

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            req.reqValid <= 1'b0;
            pready       <= 1'b0;
            pslverr      <= 1'b0;
        end else begin
            pready  <= 1'b0;                   // Single cycle unless set below
            pslverr <= 1'b0;
            if (setupPhase && addrBad) begin
                pready  <= 1'b1;               // Error ends in the first access cycle
                pslverr <= 1'b1;
            end else if (setupPhase) begin
                req.reqValid <= 1'b1;
            end
            if (req.reqDone) begin
                req.reqValid <= 1'b0;
                pready       <= 1'b1;
            end
        end
    end

    // Request fields and read data
    always_ff @(posedge Clock) begin
        if (setupPhase) begin
            req.reqAddr  <= setupAddr;
            req.reqWrite <= pwrite;
            req.reqWdata <= pwdata[dataWidth-1:0];
        end
        if (setupPhase && addrBad) begin
            prdata <= '0;
        end else if (req.reqDone && !req.reqWrite) begin
            prdata <= 32'(req.rdata);          // Zero extended
        end
    end

endmodule

//--- logic/refreshTimer.sv
/*
 * Free running auto-refresh timer. Raises a sticky request every
 * refreshInterval cycles and drops it on the controller's acknowledge.
 */
module refreshTimer (
    input  logic Clock,
    input  logic rstN,
    input  logic refreshAck,
    output logic refreshReq
);
    import sdramPkg::*;

    logic [refreshCntWidth-1:0] count;
    logic                       wrap;

    assign wrap = (count == refreshCntWidth'(refreshInterval - 1));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            count      <= '0;
            refreshReq <= 1'b0;
        end else begin
            count <= wrap ? '0 : count + 1'b1;
            if (wrap) begin
                refreshReq <= 1'b1;            // A new period wins over the ack
            end else if (refreshAck) begin
                refreshReq <= 1'b0;
            end
        end
    end

endmodule

//--- logic/sdramCtrl.sv
/*
 * SDRAM command FSM. Runs the power-up sequence, periodic auto-refresh and
 * single word accesses as activate, read or write, then precharge.
 */
module sdramCtrl (
    input  logic                              Clock,
    input  logic                              rstN,
    input  logic                              refreshReq,
    output logic                              refreshAck,
    sdramReqIf.ctrl                           req,
    output logic [sdramPkg::rowWidth-1:0]     dramAddr,
    output logic [1:0]                        dramBa,
    output logic                              dramRasN,
    output logic                              dramCasN,
    output logic                              dramWeN,
    output logic                              dramCsN,
    output logic                              dramCke,
    output logic                              dramDqml,
    output logic                              dramDqmh,
    output logic [sdramPkg::dataWidth-1:0]    dramDqOut,
    output logic                              dramDqOe,
    input  logic [sdramPkg::dataWidth-1:0]    dramDqIn
);
    import sdramPkg::*;

    sdramStateE              state, nextState;
    logic [cntWidth-1:0]     delayCnt, nextDelay;
    logic                    delayDone;
    logic [initRefWidth-1:0] initRefCnt;     // Init refreshes issued so far
    sdramCmdE                cmdQ, nextCmd;
    logic [rowWidth-1:0]     nextAddr;
    logic [1:0]              nextBa;
    logic                    nextDqOe;
    logic                    rdSample;

    assign delayDone  = (delayCnt == '0);
    assign refreshAck = (state == IDLE) && refreshReq;
    assign req.reqDone = (state == PRECHARGE) && delayDone;
    assign rdSample   = (state == READ) && delayDone;  // CL cycles after the READ command

    // Fixed pin levels, no power-down and no masking
    assign dramCke  = 1'b1;
    assign dramCsN  = 1'b0;
    assign dramDqml = 1'b0;
    assign dramDqmh = 1'b0;

    assign {dramRasN, dramCasN, dramWeN} = cmdQ;

    // ----------------------------------------
    // Next state and next command
    // ----------------------------------------
    // The command for a state is registered on the edge that enters it,
    // so it shows on the pins during the state's first cycle.
    always_comb begin
        nextState = state;
        nextDelay = delayDone ? '0 : delayCnt - 1'b1;
        nextCmd   = CMD_NOP;
        nextAddr  = '0;
        nextBa    = '0;
        nextDqOe  = 1'b0;
        case (state)
            INIT_WAIT: begin
                if (delayDone) begin
                    nextState    = INIT_PREA;
                    nextDelay    = cntWidth'(tRP - 1);
                    nextCmd      = CMD_PRECHARGE;
                    nextAddr[10] = 1'b1;            // All banks
                end
            end
            INIT_PREA: begin
                if (delayDone) begin
                    nextState = INIT_REFRESH;
                    nextDelay = '0;
                    nextCmd   = CMD_AUTO_REFRESH;
                end
            end
            INIT_REFRESH: begin
                nextState = INIT_NOP;               // Refresh cycle plus tRC-1 NOPs
                nextDelay = cntWidth'(tRC - 2);
            end
            INIT_NOP: begin
                if (delayDone && initRefCnt == initRefWidth'(initRefreshCount)) begin
                    nextState = INIT_MODE;
                    nextDelay = cntWidth'(tMRD - 1);
                    nextCmd   = CMD_MODE_SET;
                    nextAddr  = modeRegValue;
                end else if (delayDone) begin
                    nextState = INIT_REFRESH;
                    nextDelay = '0;
                    nextCmd   = CMD_AUTO_REFRESH;
                end
            end
            INIT_MODE: begin
                if (delayDone) begin
                    nextState = IDLE;
                    nextDelay = '0;
                end
            end
            IDLE: begin
                if (refreshReq) begin               // Refresh before a waiting access
                    nextState = REFRESH;
                    nextDelay = cntWidth'(tRC - 1);
                    nextCmd   = CMD_AUTO_REFRESH;
                end else if (req.reqValid) begin
                    nextState = ACTIVATE;
                    nextDelay = cntWidth'(tRCD - 1);
                    nextCmd   = CMD_ACTIVATE;
                    nextAddr  = req.reqAddr.fields.row;
                    nextBa    = req.reqAddr.fields.bank;
                end
            end
            ACTIVATE: begin
                if (delayDone) begin
                    nextAddr = rowWidth'(req.reqAddr.fields.col);  // A10 low, no auto precharge
                    nextBa   = req.reqAddr.fields.bank;
                    if (req.reqWrite) begin
                        nextState = WRITE;
                        nextDelay = cntWidth'(tDPL);
                        nextCmd   = CMD_WRITE;
                        nextDqOe  = 1'b1;
                    end else begin
                        nextState = READ;
                        nextDelay = cntWidth'(casLatency);
                        nextCmd   = CMD_READ;
                    end
                end
            end
            READ, WRITE: begin
                if (delayDone) begin
                    nextState    = PRECHARGE;
                    nextDelay    = cntWidth'(tRP - 1);
                    nextCmd      = CMD_PRECHARGE;
                    nextAddr[10] = 1'b1;
                end
            end
            PRECHARGE, REFRESH: begin
                if (delayDone) begin
                    nextState = IDLE;
                    nextDelay = '0;
                end
            end
            default: begin
                nextState = IDLE;
                nextDelay = '0;
            end
        endcase
    end

    // ----------------------------------------
    // State and pin registers
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state      <= INIT_WAIT;
            delayCnt   <= cntWidth'(initWaitCycles - 1);
            initRefCnt <= '0;
            cmdQ       <= CMD_NOP;
            dramAddr   <= '0;
            dramBa     <= '0;
            dramDqOe   <= 1'b0;
        end else begin
            state    <= nextState;
            delayCnt <= nextDelay;
            cmdQ     <= nextCmd;
            dramAddr <= nextAddr;
            dramBa   <= nextBa;
            dramDqOe <= nextDqOe;               // High for the write command cycle only
            if (state == INIT_REFRESH) begin
                initRefCnt <= initRefCnt + 1'b1;
            end
        end
    end

    // Write data out and read data capture
    always_ff @(posedge Clock) begin
        if (nextDqOe) begin
            dramDqOut <= req.reqWdata;
        end
        if (rdSample) begin
            req.rdata <= dramDqIn;
        end
    end

endmodule

//--- logic/sdramTop.sv
/*
 * SDRAM controller top level. Connects the APB bridge, the refresh timer
 * and the command FSM to the APB slave port and the SDRAM pins.
 */
module sdramTop (
    input  logic                              Clock,
    input  logic                              rstN,

    // APB slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,

    // SDRAM pins
    output logic [sdramPkg::rowWidth-1:0]     dramAddr,
    output logic [1:0]                        dramBa,
    output logic                              dramRasN,
    output logic                              dramCasN,
    output logic                              dramWeN,
    output logic                              dramCsN,
    output logic                              dramCke,
    output logic                              dramDqml,
    output logic                              dramDqmh,
    output logic [sdramPkg::dataWidth-1:0]    dramDqOut,
    output logic                              dramDqOe,     // Board wrapper builds the tristate
    input  logic [sdramPkg::dataWidth-1:0]    dramDqIn
);

    logic refreshReq;
    logic refreshAck;

    sdramReqIf reqBus ();

    apbSdramBridge apbSdramBridge_i (
        .Clock   (Clock),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (reqBus.bridge)
    );

    refreshTimer refreshTimer_i (
        .Clock      (Clock),
        .rstN       (rstN),
        .refreshAck (refreshAck),
        .refreshReq (refreshReq)
    );

    sdramCtrl sdramCtrl_i (
        .Clock      (Clock),
        .rstN       (rstN),
        .refreshReq (refreshReq),
        .refreshAck (refreshAck),
        .req        (reqBus.ctrl),
        .dramAddr   (dramAddr),
        .dramBa     (dramBa),
        .dramRasN   (dramRasN),
        .dramCasN   (dramCasN),
        .dramWeN    (dramWeN),
        .dramCsN    (dramCsN),
        .dramCke    (dramCke),
        .dramDqml   (dramDqml),
        .dramDqmh   (dramDqmh),
        .dramDqOut  (dramDqOut),
        .dramDqOe   (dramDqOe),
        .dramDqIn   (dramDqIn)
    );

endmodule

//--- bench/sdramModel.sv
/*
 * Behavioral SDRAM for the testbench. Decodes the command pins, stores
 * written words, returns reads after the CAS latency and checks the init
 * order and the timing gaps. Raises protocolError on the first violation.
 */
module sdramModel (
    input  logic                           Clock,
    input  logic                           rstN,
    input  logic [sdramPkg::rowWidth-1:0]  dramAddr,
    input  logic [1:0]                     dramBa,
    input  logic                           dramRasN,
    input  logic                           dramCasN,
    input  logic                           dramWeN,
    input  logic                           dramCsN,
    input  logic [sdramPkg::dataWidth-1:0] dramDqOut,
    input  logic                           dramDqOe,
    output logic [sdramPkg::dataWidth-1:0] dramDqIn,
    output logic                           protocolError
);
    import sdramPkg::*;

    logic [dataWidth-1:0] mem [logic [24:0]];  // Keyed by {bank, row, col}
    logic [3:0]           bankOpen;
    logic [rowWidth-1:0]  openRow [4];
    int                   actCycle [4];
    logic [24:0]          key;
    logic                 readValid;
    logic [dataWidth-1:0] readData;
    logic                 prechargeSeen;
    logic                 modeSet;
    int                   initRefreshes;
    int                   cycle;
    int                   lastRefresh;
    int                   lastPrecharge;
    int                   lastWrite;
    sdramCmdE             cmd;

    assign cmd = sdramCmdE'({dramRasN, dramCasN, dramWeN});

    // Never-written locations read back as a pattern of the full address
    function automatic logic [dataWidth-1:0] fillWord(input logic [24:0] k);
        return k[15:0] ^ 16'(k[24:16]);
    endfunction

    task automatic reportError(input string msg);
        $display("SDRAM model: %s at cycle %0d", msg, cycle);
        protocolError = 1'b1;
    endtask

    initial begin
        protocolError = 1'b0;
        dramDqIn      = '0;
        readValid     = 1'b0;
        readData      = '0;
        bankOpen      = 4'b0000;
        prechargeSeen = 1'b0;
        modeSet       = 1'b0;
        initRefreshes = 0;
        cycle         = 0;
        lastRefresh   = -100;
        lastPrecharge = -100;
        lastWrite     = -100;
    end

    always @(posedge Clock) begin
        cycle = cycle + 1;
        key   = {dramBa, openRow[dramBa], dramAddr[9:0]};
        readValid <= 1'b0;
        dramDqIn  <= readValid ? readData : 'x;  // Data valid CL edges after READ
        if (rstN && !dramCsN && cmd != CMD_NOP) begin
            if (cycle - lastRefresh < tRC) begin
                reportError("command issued inside tRC of an auto-refresh");
            end
            case (cmd)
                CMD_PRECHARGE: begin
                    if (!modeSet && !dramAddr[10]) begin
                        reportError("init precharge without A10 high");
                    end
                    if (cycle - lastWrite < tDPL) begin
                        reportError("precharge inside write recovery");
                    end
                    if (dramAddr[10]) begin
                        bankOpen = 4'b0000;
                    end else begin
                        bankOpen[dramBa] = 1'b0;
                    end
                    prechargeSeen = 1'b1;
                    lastPrecharge = cycle;
                end
                CMD_AUTO_REFRESH: begin
                    if (!prechargeSeen || |bankOpen || cycle - lastPrecharge < tRP) begin
                        reportError("auto-refresh without all banks precharged");
                    end
                    if (!modeSet) begin
                        initRefreshes = initRefreshes + 1;
                    end
                    lastRefresh = cycle;
                end
                CMD_MODE_SET: begin
                    if (modeSet || initRefreshes != initRefreshCount) begin
                        reportError("mode register set out of init order");
                    end
                    if (dramAddr != modeRegValue) begin
                        reportError("wrong mode register value");
                    end
                    modeSet = 1'b1;
                end
                CMD_ACTIVATE: begin
                    if (!modeSet) begin
                        reportError("activate before mode register set");
                    end
                    if (bankOpen[dramBa] || cycle - lastPrecharge < tRP) begin
                        reportError("activate on a bank that is not precharged");
                    end
                    bankOpen[dramBa] = 1'b1;
                    openRow[dramBa]  = dramAddr;
                    actCycle[dramBa] = cycle;
                end
                CMD_READ, CMD_WRITE: begin
                    if (!bankOpen[dramBa] || cycle - actCycle[dramBa] < tRCD) begin
                        reportError("column command without tRCD after activate");
                    end
                    if (cmd == CMD_WRITE) begin
                        if (!dramDqOe) begin
                            reportError("write command without data enable");
                        end
                        mem[key]  = dramDqOut;
                        lastWrite = cycle;
                    end else begin
                        readValid <= 1'b1;
                        readData  <= mem.exists(key) ? mem[key] : fillWord(key);
                    end
                end
                default: reportError("unknown command on the pins");
            endcase
        end
    end

endmodule

//--- bench/sdramTb.sv
/*
 * Testbench for the SDRAM controller. Drives APB transfers from the case
 * file and a run of random transfers, checks read data and PSLVERR, and
 * watches the command pins for refresh gaps.
 */
module sdramTb;
    import sdramPkg::*;

    localparam int randomCount   = 200;
    localparam int accessCycles  = 1 + tRCD + tDPL + 1 + tRP;   // Worst-case access
    localparam int maxRefreshGap = refreshInterval + accessCycles;
    localparam int initCycles    = 4 + initWaitCycles + tRP + initRefreshCount * tRC + tMRD;

    logic                 Clock;
    logic                 rstN;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [31:0]          paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic [rowWidth-1:0]  dramAddr;
    logic [1:0]           dramBa;
    logic                 dramRasN;
    logic                 dramCasN;
    logic                 dramWeN;
    logic                 dramCsN;
    logic                 dramCke;
    logic                 dramDqml;
    logic                 dramDqmh;
    logic [dataWidth-1:0] dramDqOut;
    logic                 dramDqOe;
    logic [dataWidth-1:0] dramDqIn;
    logic                 protocolError;
    logic [2:0]           cmdPins;

    logic [7:0]           opQ [$];
    logic [31:0]          addrQ [$];
    logic [31:0]          dataQ [$];
    string                nameQ [$];
    logic [15:0]          shadow [logic [31:0]];  // Expected contents by address
    int                   idleCycles;
    int                   timeoutLimit;
    int                   cycleCount;
    int                   accessCmdCount;         // Commands other than NOP and refresh
    int                   lastRefreshCycle;
    int                   periodicRefreshes;
    logic                 modeSetSeen;

    assign cmdPins = {dramRasN, dramCasN, dramWeN};

    sdramTop sdramTop_i (.*);

    sdramModel memModel (.*);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at cycle %0d", cycleCount);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Outputs while rstN is still low
    task automatic checkResetState();
        checkValue("reset pready", 32'b0, 32'(pready));
        checkValue("reset pslverr", 32'b0, 32'(pslverr));
        checkValue("reset dramDqOe", 32'b0, 32'(dramDqOe));
        checkValue("reset command pins", 32'(CMD_NOP), 32'(cmdPins));
    endtask

    // ----------------------------------------
    // APB master, one transfer
    // ----------------------------------------
    task automatic apbTransfer(input logic isWrite, input logic [31:0] addr,
                               input logic [15:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(posedge Clock);
        #2;
        psel    = 1'b1;                 // Setup phase
        penable = 1'b0;
        pwrite  = isWrite;
        paddr   = addr;
        pwdata  = {16'h0000, wdata};
        @(posedge Clock);
        #2;
        penable = 1'b1;
        @(negedge Clock);
        while (!pready) begin
            @(negedge Clock);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge Clock);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic loadCases();
        int          fd;
        int          got;
        string       line;
        string       name;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen("bench/sdramCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file bench/sdramCases.txt");
            abortRun();
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got == 0 || line.len() < 3 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%c %h %h %s", op, addr, data, name) != 4) begin
                $display("malformed line in the case file: %s", line);
                abortRun();
            end
            opQ.push_back(op);
            addrQ.push_back(addr);
            dataQ.push_back(data);
            nameQ.push_back(name);
            if (op == "I") begin
                idleCycles = idleCycles + int'(data);
            end
        end
        $fclose(fd);
    endtask

    task automatic runCases();
        int          i;
        int          cmdsBefore;
        logic        expectErr;
        logic        err;
        logic [31:0] rdata;
        for (i = 0; i < opQ.size(); i++) begin
            if (opQ[i] == "I") begin
                repeat (dataQ[i]) @(posedge Clock);
                continue;
            end
            expectErr  = (addrQ[i][31:26] != 6'd0);  // Beyond the part's address space
            cmdsBefore = accessCmdCount;
            apbTransfer(opQ[i] == "W", addrQ[i], dataQ[i][15:0], rdata, err);
            checkValue({nameQ[i], " pslverr"}, 32'(expectErr), 32'(err));
            if (expectErr) begin
                repeat (accessCycles) @(posedge Clock);  // Room for a stray access to show
                #2;
                checkValue({nameQ[i], " commands"}, cmdsBefore, accessCmdCount);
            end else if (opQ[i] == "W") begin
                shadow[addrQ[i]] = dataQ[i][15:0];
            end else begin
                checkValue(nameQ[i], {16'h0000, dataQ[i][15:0]}, rdata);
            end
        end
    endtask

    task automatic runRandom();
        int          i;
        logic [31:0] rndState;
        logic [31:0] pool [16];
        logic [31:0] addr;
        logic [31:0] rdata;
        logic        err;
        logic        doWrite;
        rndState = 32'd59695;
        for (i = 0; i < 16; i++) begin
            rndState = xorshift(rndState);
            pool[i]  = {6'b000000, rndState[25:1], 1'b0};
        end
        for (i = 0; i < randomCount; i++) begin
            rndState = xorshift(rndState);
            addr     = pool[rndState[3:0]];
            doWrite  = rndState[4] || !shadow.exists(addr);  // Read only what is known
            apbTransfer(doWrite, addr, rndState[31:16], rdata, err);
            checkValue($sformatf("random %0d pslverr", i), 32'b0, 32'(err));
            if (doWrite) begin
                shadow[addr] = rndState[31:16];
            end else begin
                checkValue($sformatf("random %0d read", i), {16'h0000, shadow[addr]}, rdata);
            end
        end
    endtask

    // ----------------------------------------
    // Cycle count, timeout and refresh watch
    // ----------------------------------------
    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            $display("timeout, the run did not finish within %0d cycles", timeoutLimit);
            abortRun();
        end
        checkValue("dramCke", 32'd1, 32'(dramCke));    // No power-down
        checkValue("dramCsN", 32'd0, 32'(dramCsN));
        checkValue("dramDqml", 32'd0, 32'(dramDqml));  // No byte masking
        checkValue("dramDqmh", 32'd0, 32'(dramDqmh));
        if (rstN && !dramCsN) begin
            if (cmdPins != CMD_NOP && cmdPins != CMD_AUTO_REFRESH) begin
                accessCmdCount = accessCmdCount + 1;
            end
            if (cmdPins == CMD_MODE_SET) begin
                modeSetSeen = 1'b1;
            end
            if (cmdPins == CMD_AUTO_REFRESH) begin
                if (lastRefreshCycle >= 0 && cycleCount - lastRefreshCycle > maxRefreshGap) begin
                    $display("auto-refresh gap of %0d cycles is over the limit of %0d",
                             cycleCount - lastRefreshCycle, maxRefreshGap);
                    abortRun();
                end
                if (modeSetSeen) begin
                    periodicRefreshes = periodicRefreshes + 1;
                end
                lastRefreshCycle = cycleCount;
            end
        end
    end

    always @(posedge protocolError) begin
        abortRun();
    end

    initial begin
        rstN              = 1'b0;
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        paddr             = '0;
        pwdata            = '0;
        idleCycles        = 0;
        cycleCount        = 0;
        accessCmdCount    = 0;
        lastRefreshCycle  = -1;
        periodicRefreshes = 0;
        modeSetSeen       = 1'b0;
        timeoutLimit      = initCycles + 1000;
        loadCases();
        timeoutLimit = initCycles + (opQ.size() + randomCount) * 40 + idleCycles + 1000;
        repeat (4) @(posedge Clock);
        #2;
        checkResetState();
        rstN = 1'b1;
        runCases();
        runRandom();
        if (periodicRefreshes == 0) begin
            $display("no periodic auto-refresh was seen after init");
            abortRun();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- bench/sdramCases.txt
# op address data name, all numbers hex; W writes data, R expects data, I idles data cycles
# address bits 25:24 bank, 23:11 row, 10:1 column; any of bits 31:26 set is out of range
W 00000000 a5a5 firstWriteDuringInit
R 00000000 a5a5 bank0Row0Col0
W 010007fe 1234 bank1LastCol
W 02fff800 5678 bank2LastRow
W 03fffffe 9abc bank3LastRowLastCol
R 010007fe 1234 readBank1LastCol
R 02fff800 5678 readBank2LastRow
R 03fffffe 9abc readBank3LastRowLastCol
W 00000010 1111 indepBank0
W 01000010 2222 indepBank1
W 02000010 3333 indepBank2
W 03000010 4444 indepBank3
W 00000810 5555 indepRow1
W 00000012 6666 indepCol9
R 00000010 1111 readIndepBank0
R 01000010 2222 readIndepBank1
R 02000010 3333 readIndepBank2
R 03000010 4444 readIndepBank3
R 00000810 5555 readIndepRow1
R 00000012 6666 readIndepCol9
I 00000000 00000320 idleAcrossRefreshes
W 04000010 dead outOfRangeWrite
R 80000010 0000 outOfRangeRead
R 00000010 1111 aliasKeepsValue

//--- src.f
logic/sdramPkg.sv
logic/sdramReqIf.sv
logic/apbSdramBridge.sv
logic/refreshTimer.sv
logic/sdramCtrl.sv
logic/sdramTop.sv
bench/sdramModel.sv
bench/sdramTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
# The exit status is nonzero when the build fails or the run ends in $fatal.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module sdramTb -f src.f -o sdramSim \
    && ./obj_dir/sdramSim \
    || exit 1
